// ==== logic/ilk_tx_pkg.sv ====
// shared widths and types of the tx channel mux, which is built for exactly four channels of 64-bit words
package ilk_tx_pkg;

	////////////////////
	// widths

	// one data word on the link is always 64 bits wide
	localparam int word_w = 64;

	// the arbiter port list is written out per channel, so this stays fixed
	localparam int num_chans = 4;

	////////////////////
	// beat fields

	// tag that travels with every output beat to name its channel
	typedef logic [7:0] chan_id_t;

	// eop field of a beat, four bits in total
	// last is bit 3 and marks the final beat of a packet
	// last_bytes is the count of valid bytes in the final word, where 0 means all 8
	typedef struct packed {
		logic       last;
		logic [2:0] last_bytes;
	} eop_t;

	////////////////////
	// arbiter

	// encoded form of the one-hot channel grant
	typedef enum logic [1:0] {
		sel_chan0 = 2'd0,
		sel_chan1 = 2'd1,
		sel_chan2 = 2'd2,
		sel_chan3 = 2'd3
	} chan_sel_t;

endpackage

// ==== logic/rr_grant.sv ====
// combinational priority search over four requests; base must be one-hot or the grant is meaningless
`timescale 1ns/10ps

module rr_grant import ilk_tx_pkg::*; (
	input  logic [num_chans-1:0] req,
	input  logic [num_chans-1:0] base,
	output logic [num_chans-1:0] grant
);

	// the request vector is laid out twice so that the search can wrap
	logic [2*num_chans-1:0] req_twice;
	logic [2*num_chans-1:0] won_twice;

	always_comb begin
		req_twice = {req, req};

		// subtracting the base clears every request bit from the base up to
		// the first one that is set, so the first requester at or after the
		// base is the only bit that survives the mask
		won_twice = req_twice & ~(req_twice - {{num_chans{1'b0}}, base});

		// fold the upper copy back, which covers the wrapped case
		grant = won_twice[num_chans-1:0] | won_twice[2*num_chans-1:num_chans];

		// ignore the cycles before reset has settled the request and base
		if (!$isunknown({req, base})) begin
			assert ($onehot0(grant) && ((grant & ~req) == '0))
			else $error("rr_grant gave %b for req %b base %b", grant, req, base);
		end
	end

endmodule

// ==== logic/chan_queue.sv ====
// per-channel beat queue; QUEUE_DEPTH must be a power of two and at least 2, and pushing while full is illegal
`timescale 1ns/10ps

module chan_queue import ilk_tx_pkg::*; #(
	parameter int NUM_DAT_WORDS = 8,
	parameter int QUEUE_DEPTH = 8,
	localparam int count_w = $clog2(NUM_DAT_WORDS + 1),
	localparam int beat_w = word_w * NUM_DAT_WORDS
) (
	input  logic               clk,
	input  logic               arst,
	input  logic               push,
	input  logic [beat_w-1:0]  words,
	input  logic [count_w-1:0] count,
	input  logic               sop,
	input  eop_t               eop,
	input  logic               ready,
	output logic               full,
	output logic               valid,
	output logic [beat_w-1:0]  q_words,
	output logic [count_w-1:0] q_count,
	output logic               q_sop,
	output eop_t               q_eop
);

	localparam int ptr_w = $clog2(QUEUE_DEPTH);
	localparam int occ_w = $clog2(QUEUE_DEPTH + 1);
	localparam logic [occ_w-1:0] full_lvl = occ_w'(QUEUE_DEPTH);

	logic [beat_w-1:0]  mem_words [QUEUE_DEPTH];
	logic [count_w-1:0] mem_count [QUEUE_DEPTH];
	logic               mem_sop [QUEUE_DEPTH];
	eop_t               mem_eop [QUEUE_DEPTH];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [occ_w-1:0] occ;
	logic             pop;

	// the arbiter can hold ready on a stale grant, so only a non-empty queue pops
	assign pop = ready & valid;

	////////////////////
	// storage

	always_ff @(posedge clk) begin
		if (push) begin
			mem_words[wr_ptr] <= words;
			mem_count[wr_ptr] <= count;
			mem_sop[wr_ptr] <= sop;
			mem_eop[wr_ptr] <= eop;
		end
	end

	////////////////////
	// pointers and occupancy

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// a push and a pop together leave the level where it was
			case ({push, pop})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	assign full = (occ == full_lvl);
	assign valid = (occ != '0);

	// head of the queue goes straight out
	assign q_words = mem_words[rd_ptr];
	assign q_count = mem_count[rd_ptr];
	assign q_sop = mem_sop[rd_ptr];
	assign q_eop = mem_eop[rd_ptr];

	////////////////////
	// checks

	push_while_full: assert property (@(posedge clk) disable iff (arst) push |-> !full)
		else $error("chan_queue push while full");

endmodule

// ==== logic/chan_arbiter.sv ====
// four-channel rotating arbiter with a registered output; requests lag the queues by a cycle so stale grants can occur
`timescale 1ns/10ps

module chan_arbiter import ilk_tx_pkg::*; #(
	parameter int NUM_DAT_WORDS = 8,
	parameter chan_id_t CHAN_ID0 = 8'h00,
	parameter chan_id_t CHAN_ID1 = 8'h01,
	parameter chan_id_t CHAN_ID2 = 8'h02,
	parameter chan_id_t CHAN_ID3 = 8'h03,
	localparam int count_w = $clog2(NUM_DAT_WORDS + 1),
	localparam int beat_w = word_w * NUM_DAT_WORDS
) (
	input  logic                 clk,
	input  logic                 arst,
	input  logic [num_chans-1:0] channel_enables,

	// channel 0
	input  logic [count_w-1:0]   chan0_count,
	input  logic [beat_w-1:0]    chan0_words,
	input  logic                 chan0_sop,
	input  eop_t                 chan0_eop,
	input  logic                 chan0_valid,
	output logic                 chan0_ready,

	// channel 1
	input  logic [count_w-1:0]   chan1_count,
	input  logic [beat_w-1:0]    chan1_words,
	input  logic                 chan1_sop,
	input  eop_t                 chan1_eop,
	input  logic                 chan1_valid,
	output logic                 chan1_ready,

	// channel 2
	input  logic [count_w-1:0]   chan2_count,
	input  logic [beat_w-1:0]    chan2_words,
	input  logic                 chan2_sop,
	input  eop_t                 chan2_eop,
	input  logic                 chan2_valid,
	output logic                 chan2_ready,

	// channel 3
	input  logic [count_w-1:0]   chan3_count,
	input  logic [beat_w-1:0]    chan3_words,
	input  logic                 chan3_sop,
	input  eop_t                 chan3_eop,
	input  logic                 chan3_valid,
	output logic                 chan3_ready,

	// merged output
	output logic [count_w-1:0]   out_count,
	output logic [beat_w-1:0]    out_words,
	output chan_id_t             out_chan,
	output logic                 out_sop,
	output eop_t                 out_eop,
	output logic                 out_valid,
	input  logic                 out_ready
);

	localparam chan_id_t chan_ids [num_chans] = '{CHAN_ID0, CHAN_ID1, CHAN_ID2, CHAN_ID3};

	// channel inputs gathered so the output mux can index them
	logic [count_w-1:0]   cnt [num_chans];
	logic [beat_w-1:0]    wrd [num_chans];
	eop_t                 eop_v [num_chans];
	logic [num_chans-1:0] sop_v;
	logic [num_chans-1:0] vld;

	logic [num_chans-1:0] req;
	logic [num_chans-1:0] base;
	logic [num_chans-1:0] grant;
	logic [num_chans-1:0] grant_next;
	chan_sel_t            grant_sel;
	chan_sel_t            sel_next;

	assign cnt = '{chan0_count, chan1_count, chan2_count, chan3_count};
	assign wrd = '{chan0_words, chan1_words, chan2_words, chan3_words};
	assign eop_v = '{chan0_eop, chan1_eop, chan2_eop, chan3_eop};
	assign sop_v = {chan3_sop, chan2_sop, chan1_sop, chan0_sop};
	assign vld = {chan3_valid, chan2_valid, chan1_valid, chan0_valid};

	////////////////////
	// request stage

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			req <= '0;
		end else begin
			for (int c = 0; c < num_chans; c++) begin
				req[c] <= channel_enables[c] & vld[c] & (|cnt[c]);
			end
		end
	end

	////////////////////
	// rotating grant

	rr_grant rr_grant_inst (
		.req   (req),
		.base  (base),
		.grant (grant_next)
	);

	// binary form of the one-hot winner
	assign sel_next = chan_sel_t'({grant_next[3] | grant_next[2], grant_next[3] | grant_next[1]});

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			base <= num_chans'(1);
			grant <= '0;
			grant_sel <= sel_chan0;
		end else if (out_ready) begin
			base <= {base[num_chans-2:0], base[num_chans-1]};
			grant <= grant_next;
			grant_sel <= sel_next;
		end
	end

	////////////////////
	// output register

	// a granted channel may have drained since its request was sampled
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			out_count <= '0;
		end else if (out_ready) begin
			if (|grant) begin
				out_count <= cnt[grant_sel] & {count_w{vld[grant_sel]}};
			end else begin
				out_count <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_ready) begin
			out_words <= wrd[grant_sel];
			out_sop <= sop_v[grant_sel];
			out_eop <= eop_v[grant_sel];
			out_chan <= chan_ids[grant_sel];
		end
	end

	assign {chan3_ready, chan2_ready, chan1_ready, chan0_ready} = grant & {num_chans{out_ready}};
	assign out_valid = |out_count;

	////////////////////
	// checks

	grant_onehot: assert property (
		@(posedge clk) disable iff (arst) $onehot(base) && $onehot0(grant)
	) else $error("chan_arbiter grant %b not one-hot, sel %s", grant, grant_sel.name());

endmodule

// ==== logic/ilk_tx_mux.sv ====
// top of the tx channel mux with four queues; pushes must respect in_full and out_ready is a plain level
`timescale 1ns/10ps

module ilk_tx_mux import ilk_tx_pkg::*; #(
	parameter int NUM_DAT_WORDS = 8,
	parameter int QUEUE_DEPTH = 8,
	parameter chan_id_t CHAN_ID0 = 8'h00,
	parameter chan_id_t CHAN_ID1 = 8'h01,
	parameter chan_id_t CHAN_ID2 = 8'h02,
	parameter chan_id_t CHAN_ID3 = 8'h03,
	localparam int count_w = $clog2(NUM_DAT_WORDS + 1),
	localparam int beat_w = word_w * NUM_DAT_WORDS
) (
	input  logic                              clk,
	input  logic                              arst,

	// host side, one lane per channel
	input  logic [num_chans-1:0]              in_push,
	input  logic [num_chans-1:0][beat_w-1:0]  in_words,
	input  logic [num_chans-1:0][count_w-1:0] in_count,
	input  logic [num_chans-1:0]              in_sop,
	input  eop_t [num_chans-1:0]              in_eop,
	output logic [num_chans-1:0]              in_full,
	input  logic [num_chans-1:0]              channel_enables,

	// link side
	output logic [count_w-1:0]                out_count,
	output logic [beat_w-1:0]                 out_words,
	output chan_id_t                          out_chan,
	output logic                              out_sop,
	output eop_t                              out_eop,
	output logic                              out_valid,
	input  logic                              out_ready
);

	logic [num_chans-1:0]              q_valid;
	logic [num_chans-1:0]              q_ready;
	logic [num_chans-1:0]              q_sop;
	logic [num_chans-1:0][beat_w-1:0]  q_words;
	logic [num_chans-1:0][count_w-1:0] q_count;
	eop_t [num_chans-1:0]              q_eop;

	for (genvar c = 0; c < num_chans; c++) begin : g_queue
		chan_queue #(
			.NUM_DAT_WORDS (NUM_DAT_WORDS),
			.QUEUE_DEPTH   (QUEUE_DEPTH)
		) chan_queue_inst (
			.clk     (clk),
			.arst    (arst),
			.push    (in_push[c]),
			.words   (in_words[c]),
			.count   (in_count[c]),
			.sop     (in_sop[c]),
			.eop     (in_eop[c]),
			.ready   (q_ready[c]),
			.full    (in_full[c]),
			.valid   (q_valid[c]),
			.q_words (q_words[c]),
			.q_count (q_count[c]),
			.q_sop   (q_sop[c]),
			.q_eop   (q_eop[c])
		);
	end

	chan_arbiter #(
		.NUM_DAT_WORDS (NUM_DAT_WORDS),
		.CHAN_ID0      (CHAN_ID0),
		.CHAN_ID1      (CHAN_ID1),
		.CHAN_ID2      (CHAN_ID2),
		.CHAN_ID3      (CHAN_ID3)
	) chan_arbiter_inst (
		.clk             (clk),
		.arst            (arst),
		.channel_enables (channel_enables),
		.chan0_count     (q_count[0]),
		.chan0_words     (q_words[0]),
		.chan0_sop       (q_sop[0]),
		.chan0_eop       (q_eop[0]),
		.chan0_valid     (q_valid[0]),
		.chan0_ready     (q_ready[0]),
		.chan1_count     (q_count[1]),
		.chan1_words     (q_words[1]),
		.chan1_sop       (q_sop[1]),
		.chan1_eop       (q_eop[1]),
		.chan1_valid     (q_valid[1]),
		.chan1_ready     (q_ready[1]),
		.chan2_count     (q_count[2]),
		.chan2_words     (q_words[2]),
		.chan2_sop       (q_sop[2]),
		.chan2_eop       (q_eop[2]),
		.chan2_valid     (q_valid[2]),
		.chan2_ready     (q_ready[2]),
		.chan3_count     (q_count[3]),
		.chan3_words     (q_words[3]),
		.chan3_sop       (q_sop[3]),
		.chan3_eop       (q_eop[3]),
		.chan3_valid     (q_valid[3]),
		.chan3_ready     (q_ready[3]),
		.out_count       (out_count),
		.out_words       (out_words),
		.out_chan        (out_chan),
		.out_sop         (out_sop),
		.out_eop         (out_eop),
		.out_valid       (out_valid),
		.out_ready       (out_ready)
	);

endmodule

// ==== dv/tb_checks.svh ====
// helpers included inside the testbench module; they rely on its rng_state, model_q and abort_run
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// random numbers

// 32-bit xorshift step on the shared generator state
function automatic logic [31:0] next_random();
	logic [31:0] s;
	s = rng_state;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	rng_state = s;
	return s;
endfunction

////////////////////
// compare tasks

task automatic compare_beat(
	input string              what,
	input logic [beat_w-1:0]  got_words,
	input logic [beat_w-1:0]  exp_words,
	input logic [count_w-1:0] got_count,
	input logic [count_w-1:0] exp_count,
	input logic               got_sop,
	input logic               exp_sop,
	input eop_t               got_eop,
	input eop_t               exp_eop,
	input chan_id_t           got_chan,
	input chan_id_t           exp_chan
);
	if (got_words !== exp_words || got_count !== exp_count || got_sop !== exp_sop
			|| got_eop !== exp_eop || got_chan !== exp_chan) begin
		abort_run($sformatf(
			"** Error at %0t: %s got chan %h count %0d sop %b eop %h words %h, %s %h %0d %b %h %h",
			$time, what, got_chan, got_count, got_sop, got_eop, got_words, "expected",
			exp_chan, exp_count, exp_sop, exp_eop, exp_words));
	end
endtask

task automatic compare_level(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
	end
endtask

////////////////////
// waits

function automatic int pending_beats();
	int total;
	total = 0;
	for (int c = 0; c < num_chans; c++) begin
		total += model_q[c].size();
	end
	return total;
endfunction

// runs idle cycles with the output always ready until every channel is empty
task automatic wait_drained(input int limit);
	int n;
	n = 0;
	while (pending_beats() != 0) begin
		if (n == limit) begin
			abort_run("timeout: the channel queues did not drain");
		end
		drive_cycle('0, 100);
		n++;
	end
endtask

// pushes one channel until its queue reports full
task automatic wait_full(input int c, input int limit);
	int n;
	n = 0;
	while (!in_full[c]) begin
		if (n == limit) begin
			abort_run($sformatf("timeout: channel %0d never reported full", c));
		end
		drive_cycle(num_chans'(1 << c), 100);
		n++;
	end
endtask

`endif

// ==== dv/tb_ilk_tx_mux.sv ====
// testbench of the tx channel mux with two words per beat; fixed-seed random traffic checked against per-channel queues
`timescale 1ns/10ps

module tb_ilk_tx_mux import ilk_tx_pkg::*; ();

	localparam int n_words = 2;
	localparam int depth = 8;
	localparam int count_w = $clog2(n_words + 1);
	localparam int beat_w = word_w * n_words;
	localparam chan_id_t ids [num_chans] = '{8'h10, 8'h21, 8'h32, 8'h43};

	typedef struct packed {
		logic [beat_w-1:0]  words;
		logic [count_w-1:0] count;
		logic               sop;
		eop_t               eop;
	} beat_t;

	logic                              clk;
	logic                              arst;
	logic [num_chans-1:0]              in_push;
	logic [num_chans-1:0][beat_w-1:0]  in_words;
	logic [num_chans-1:0][count_w-1:0] in_count;
	logic [num_chans-1:0]              in_sop;
	eop_t [num_chans-1:0]              in_eop;
	logic [num_chans-1:0]              in_full;
	logic [num_chans-1:0]              channel_enables;
	logic [count_w-1:0]                out_count;
	logic [beat_w-1:0]                 out_words;
	chan_id_t                          out_chan;
	logic                              out_sop;
	eop_t                              out_eop;
	logic                              out_valid;
	logic                              out_ready;

	// scoreboard and monitor state
	beat_t                model_q [num_chans][$];
	logic [31:0]          rng_state;
	logic                 checking;
	logic                 prev_ready;
	logic                 prev_valid;
	beat_t                prev_beat;
	chan_id_t             prev_chan;
	logic [num_chans-1:0] en_last;
	logic [num_chans-1:0] req_last;
	logic [num_chans-1:0] gnt_last;
	int                   starve [num_chans];

	ilk_tx_mux #(
		.NUM_DAT_WORDS (n_words),
		.QUEUE_DEPTH   (depth),
		.CHAN_ID0      (8'h10),
		.CHAN_ID1      (8'h21),
		.CHAN_ID2      (8'h32),
		.CHAN_ID3      (8'h43)
	) ilk_tx_mux_inst (.*);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("sim failed");
		$fatal(1);
	endtask

	`include "tb_checks.svh"

	always #10 clk = ~clk;

	// one clock of stimulus, pushes only go to allowed channels that are not full
	task automatic drive_cycle(input logic [num_chans-1:0] allow, input int ready_pct);
		logic [31:0] r;
		@(posedge clk);
		#1;
		for (int c = 0; c < num_chans; c++) begin
			r = next_random();
			in_push[c] = allow[c] & ~in_full[c] & r[0];
			in_count[c] = r[1] ? count_w'(2) : count_w'(1);
			in_sop[c] = r[2];
			in_eop[c] = r[6:3];
			for (int k = 0; k < beat_w / 32; k++) begin
				in_words[c][32*k +: 32] = next_random();
			end
		end
		out_ready = int'(next_random() % 100) < ready_pct;
	endtask

	////////////////////
	// monitor

	task automatic check_cycle();
		int    ch;
		beat_t exp;
		ch = -1;
		// nothing may move while the output was stalled
		if (!prev_ready) begin
			compare_level("held out_valid", out_valid, prev_valid);
			compare_beat("held beat", out_words, prev_beat.words, out_count, prev_beat.count,
				out_sop, prev_beat.sop, out_eop, prev_beat.eop, out_chan, prev_chan);
		end
		if (prev_ready && out_valid) begin
			for (int c = 0; c < num_chans; c++) begin
				if (out_chan == ids[c]) begin
					ch = c;
				end
			end
			if (ch < 0) begin
				abort_run($sformatf("output beat carries an unknown channel id %h", out_chan));
			end
			if (!gnt_last[ch]) begin
				abort_run($sformatf("channel %0d sent a beat while it was disabled", ch));
			end
			if (model_q[ch].size() == 0) begin
				abort_run($sformatf("channel %0d sent a beat that was never pushed", ch));
			end
			exp = model_q[ch].pop_front();
			compare_beat("output beat", out_words, exp.words, out_count, exp.count,
				out_sop, exp.sop, out_eop, exp.eop, out_chan, ids[ch]);
		end
		for (int c = 0; c < num_chans; c++) begin
			compare_level($sformatf("in_full[%0d]", c), in_full[c], model_q[c].size() == depth);
			if (out_ready && prev_ready && channel_enables[c] && model_q[c].size() != 0
					&& ch != c) begin
				starve[c]++;
			end else begin
				starve[c] = 0;
			end
			if (starve[c] > 16) begin
				abort_run($sformatf("channel %0d waited more than 16 cycles for a grant", c));
			end
			if (in_push[c]) begin
				model_q[c].push_back(beat_t'{in_words[c], in_count[c], in_sop[c], in_eop[c]});
			end
		end
		// upper bound of the grant register, a request lags its enable by one clock
		gnt_last = prev_ready ? req_last : gnt_last;
		req_last = en_last;
		en_last = channel_enables;
		prev_ready = out_ready;
		prev_valid = out_valid;
		prev_beat = beat_t'{out_words, out_count, out_sop, out_eop};
		prev_chan = out_chan;
	endtask

	always @(negedge clk) begin
		if (checking) begin
			check_cycle();
		end
	end

	////////////////////
	// sequence

	initial begin
		logic [31:0]          r;
		logic [num_chans-1:0] mask;
		int                   duty;
		clk = 1'b0;
		arst = 1'b1;
		in_push = '0;
		in_words = '0;
		in_count = '0;
		in_sop = '0;
		in_eop = '0;
		channel_enables = '1;
		out_ready = 1'b0;
		rng_state = 32'd79937;
		checking = 1'b0;
		prev_ready = 1'b1;
		prev_valid = 1'b0;
		prev_beat = '0;
		prev_chan = '0;
		en_last = '0;
		req_last = '0;
		gnt_last = '0;
		for (int c = 0; c < num_chans; c++) begin
			starve[c] = 0;
		end
		repeat (2) @(posedge clk);
		#1;
		arst = 1'b0;
		checking = 1'b1;
		@(negedge clk);
		compare_level("out_valid after reset", out_valid, 1'b0);
		compare_level("any in_full after reset", |in_full, 1'b0);

		// blocks of random traffic, each with its own enable mask and ready duty
		for (int blk = 0; blk < 60; blk++) begin
			r = next_random();
			mask = r[4] ? '1 : r[3:0];
			duty = (r[6:5] == 2'd0) ? 40 : (r[5] ? 100 : 75);
			for (int i = 0; i < 64; i++) begin
				drive_cycle('1, duty);
				channel_enables = mask;
			end
		end

		// fill channel 2 while it is disabled, then release it
		channel_enables = '1;
		wait_drained(400);
		channel_enables = 4'b1011;
		wait_full(2, 100);
		for (int i = 0; i < 20; i++) begin
			drive_cycle('0, 100);
		end
		compare_level("in_full[2] while disabled", in_full[2], 1'b1);
		channel_enables = '1;
		wait_drained(400);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+dv
logic/ilk_tx_pkg.sv
logic/rr_grant.sv
logic/chan_queue.sv
logic/chan_arbiter.sv
logic/ilk_tx_mux.sv
dv/tb_ilk_tx_mux.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_ilk_tx_mux
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run status is ignored here, the log decides pass or fail
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "sim passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
